// ==== vlog.f ====
rtl/gost_sbox_pkg.sv
rtl/gost_cmd_pkg.sv
rtl/gost_cmd_decode.sv
rtl/gost_round_engine.sv
rtl/gost_result_reg.sv
rtl/gost_crypto_unit.sv
tests/tb_clock.sv
tests/tb_gost_crypto_unit.sv

// ==== Makefile ====
# Verilator build and run for the GOST crypto unit

VERILATOR ?= verilator
TOP       ?= tb_gost_crypto_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status, which fails make
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_gost_crypto_unit.sv ====
// GOST crypto unit testbench

module tb_gost_crypto_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import gost_sbox_pkg::*;
  import gost_cmd_pkg::*;

  localparam int reset_cycles   = 16;
  localparam int block_latency  = 34; // strobe to result_valid
  localparam int result_timeout = 100;

  logic               clk;
  logic               rst;
  logic               cmd_strobe;
  cmd_op_e            cmd_op;
  sbox_set_e          cmd_sbox;
  logic [key_w-1:0]   key_in;
  logic [block_w-1:0] block_in;
  logic               busy;
  logic               cmd_reject;
  logic               result_valid;
  logic [block_w-1:0] result_block;
  logic               result_decrypt;

  int               seed = 32'hd229;
  logic [key_w-1:0] cur_key; // key the DUT holds now

  tb_clock tb_clock_inst (.clk(clk));

  gost_crypto_unit gost_crypto_unit_inst (
    .clk            (clk),
    .rst            (rst),
    .cmd_strobe     (cmd_strobe),
    .cmd_op         (cmd_op),
    .cmd_sbox       (cmd_sbox),
    .key_in         (key_in),
    .block_in       (block_in),
    .busy           (busy),
    .cmd_reject     (cmd_reject),
    .result_valid   (result_valid),
    .result_block   (result_block),
    .result_decrypt (result_decrypt)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  // K0 sits in the most significant word of the key
  function automatic logic [half_w-1:0] round_key(input logic [key_w-1:0] key,
                                                  input int r, input logic dec);
    int idx;
    if (dec)
      idx = (r < 8) ? (r % 8) : (7 - r % 8);
    else
      idx = (r < 24) ? (r % 8) : (7 - r % 8);
    return key[key_w-1-half_w*idx -: half_w];
  endfunction

  function automatic logic [block_w-1:0] cipher_model(input logic [key_w-1:0] key,
                                                      input logic [block_w-1:0] blk,
                                                      input logic dec,
                                                      input sbox_set_e set);
    logic [half_w-1:0] lo;
    logic [half_w-1:0] hi;
    logic [half_w-1:0] f;
    logic [half_w-1:0] t;
    hi = blk[block_w-1:half_w];
    lo = blk[half_w-1:0];
    for (int r = 0; r < num_rounds; r++) begin
      f  = sbox_subst(lo + round_key(key, r, dec), set);
      f  = {f[20:0], f[31:21]}; // rotate left by 11
      t  = hi ^ f;
      hi = lo;
      lo = t;
    end
    return {lo, hi}; // last swap undone
  endfunction

  function automatic logic [key_w-1:0] random_key();
    logic [key_w-1:0] k;
    for (int n = 0; n < 8; n++)
      k[half_w*n +: half_w] = $random(seed);
    return k;
  endfunction

  function automatic logic [block_w-1:0] random_block();
    logic [half_w-1:0] hi;
    logic [half_w-1:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic sbox_set_e other_set(input sbox_set_e set);
    return (set == set_test) ? set_cpro : set_test;
  endfunction

  //////////////////////////////
  // reporting and compares
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_block(input string name, input logic [block_w-1:0] got,
                             input logic [block_w-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_sbox_set(input string name, input sbox_set_e got,
                                input sbox_set_e exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
  endtask

  //////////////////////////////
  // command tasks
  //////////////////////////////

  // one strobe cycle, returns at the falling edge after the sampling edge
  task automatic issue_cmd(input cmd_op_e op, input sbox_set_e set,
                           input logic [key_w-1:0] key, input logic [block_w-1:0] blk);
    @(negedge clk);
    cmd_strobe = 1'b1;
    cmd_op     = op;
    cmd_sbox   = set;
    key_in     = key;
    block_in   = blk;
    @(negedge clk);
    cmd_strobe = 1'b0;
  endtask

  task automatic wait_result(output int cycles);
    int n;
    n = 0;
    while (result_valid !== 1'b1) begin
      if (n >= result_timeout)
        abort_run("no result_valid pulse arrived before the timeout");
      @(negedge clk);
      n++;
    end
    cycles = n;
  endtask

  task automatic load_key(input logic [key_w-1:0] key);
    issue_cmd(op_load_key, set_test, key, '0);
    check_flag("cmd_reject", cmd_reject, 1'b0);
    check_flag("busy", busy, 1'b0); // key load never occupies the engine
    cur_key = key;
  endtask

  task automatic run_block(input logic dec, input sbox_set_e set,
                           input logic [block_w-1:0] blk, output logic [block_w-1:0] res);
    int cycles;
    issue_cmd(dec ? op_decrypt : op_encrypt, set, '0, blk);
    check_flag("busy", busy, 1'b1);
    check_sbox_set("sbox_sel", gost_crypto_unit_inst.sbox_sel, set);
    wait_result(cycles);
    if (cycles != block_latency)
      abort_run($sformatf("ERROR result_valid latency: got %h expected %h",
                          cycles, block_latency));
    check_flag("result_decrypt", result_decrypt, dec);
    check_flag("busy", busy, 1'b0);
    res = result_block;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_encrypt_both_sets();
    logic [block_w-1:0] blk;
    logic [block_w-1:0] res;
    load_key(random_key());
    blk = random_block();
    run_block(1'b0, set_test, blk, res);
    check_block("result_block", res, cipher_model(cur_key, blk, 1'b0, set_test));
    blk = random_block();
    run_block(1'b0, set_cpro, blk, res);
    check_block("result_block", res, cipher_model(cur_key, blk, 1'b0, set_cpro));
  endtask

  task automatic test_round_trip();
    logic [block_w-1:0] plain;
    logic [block_w-1:0] cipher;
    logic [block_w-1:0] res;
    sbox_set_e          set;
    set = set_test;
    for (int n = 0; n < 2; n++) begin
      plain = random_block();
      run_block(1'b0, set, plain, cipher);
      check_block("result_block", cipher, cipher_model(cur_key, plain, 1'b0, set));
      run_block(1'b1, set, cipher, res);
      check_block("result_block", res, plain); // back to the plaintext
      check_block("result_block", res, cipher_model(cur_key, cipher, 1'b1, set));
      set = other_set(set);
    end
  endtask

  task automatic test_wrong_set();
    logic [block_w-1:0] blk;
    logic [block_w-1:0] res_test;
    logic [block_w-1:0] res_cpro;
    blk = random_block();
    run_block(1'b0, set_test, blk, res_test);
    run_block(1'b0, set_cpro, blk, res_cpro);
    if (cipher_model(cur_key, blk, 1'b0, set_test) == cipher_model(cur_key, blk, 1'b0, set_cpro))
      abort_run("both S-box sets give the same model ciphertext for this block");
    check_block("result_block", res_test, cipher_model(cur_key, blk, 1'b0, set_test));
    check_block("result_block", res_cpro, cipher_model(cur_key, blk, 1'b0, set_cpro));
  endtask

  task automatic test_reject_while_busy();
    logic [block_w-1:0] blk;
    int                 cycles;
    blk = random_block();
    issue_cmd(op_encrypt, set_test, '0, blk);
    repeat (4) @(negedge clk);
    check_flag("busy", busy, 1'b1);
    issue_cmd(op_decrypt, set_cpro, '0, random_block()); // lands mid block
    check_flag("cmd_reject", cmd_reject, 1'b1);
    check_sbox_set("sbox_sel", gost_crypto_unit_inst.sbox_sel, set_test);
    @(negedge clk);
    check_flag("cmd_reject", cmd_reject, 1'b0);
    check_flag("busy", busy, 1'b1);
    wait_result(cycles);
    if (cycles != block_latency - 7) // seven cycles since the accepted strobe
      abort_run($sformatf("ERROR result_valid latency: got %h expected %h",
                          cycles, block_latency - 7));
    check_block("result_block", result_block, cipher_model(cur_key, blk, 1'b0, set_test));
    check_flag("result_decrypt", result_decrypt, 1'b0);
    check_flag("busy", busy, 1'b0);
  endtask

  task automatic test_reserved_and_reload();
    logic [key_w-1:0]   new_key;
    logic [block_w-1:0] blk;
    logic [block_w-1:0] res;
    sbox_set_e          prev_set;
    prev_set = gost_crypto_unit_inst.sbox_sel;
    new_key  = random_key();
    issue_cmd(op_reserved, other_set(prev_set), new_key, random_block());
    check_flag("cmd_reject", cmd_reject, 1'b1);
    check_flag("busy", busy, 1'b0);
    check_sbox_set("sbox_sel", gost_crypto_unit_inst.sbox_sel, prev_set);
    repeat (2) @(negedge clk);
    check_flag("result_valid", result_valid, 1'b0);
    // the old key must still be in use
    blk = random_block();
    run_block(1'b0, set_test, blk, res);
    check_block("result_block", res, cipher_model(cur_key, blk, 1'b0, set_test));
    load_key(new_key);
    blk = random_block();
    run_block(1'b0, set_cpro, blk, res);
    check_block("result_block", res, cipher_model(new_key, blk, 1'b0, set_cpro));
  endtask

  initial begin
    rst        = 1'b1;
    cmd_strobe = 1'b0;
    cmd_op     = op_load_key;
    cmd_sbox   = set_test;
    key_in     = '0;
    block_in   = '0;
    cur_key    = '0;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    test_encrypt_both_sets();
    test_round_trip();
    test_wrong_set();
    test_reject_while_busy();
    test_reserved_and_reload();

    $display("Test OK");
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
// testbench clock source

module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 50; // 100 ns period

  initial begin
    clk = 1'b0;
    forever begin
      #half_period;
      clk = ~clk;
    end
  end

endmodule

// ==== rtl/gost_crypto_unit.sv ====
// GOST 28147-89 ECB crypto unit

module gost_crypto_unit (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cmd_strobe,
  input  gost_cmd_pkg::cmd_op_e             cmd_op,
  input  gost_sbox_pkg::sbox_set_e          cmd_sbox,
  input  logic [gost_sbox_pkg::key_w-1:0]   key_in,
  input  logic [gost_sbox_pkg::block_w-1:0] block_in,
  output logic                              busy,
  output logic                              cmd_reject,
  output logic                              result_valid,
  output logic [gost_sbox_pkg::block_w-1:0] result_block,
  output logic                              result_decrypt
);

  import gost_sbox_pkg::*;

  // decoder to engine
  logic               key_load;
  logic               start;
  logic               decrypt;
  sbox_set_e          sbox_sel;
  logic [key_w-1:0]   key_word;
  logic [block_w-1:0] block_word;

  // engine to decoder and result register
  logic [block_w-1:0] out_block;
  logic               done;

  gost_cmd_decode gost_cmd_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .cmd_op     (cmd_op),
    .cmd_sbox   (cmd_sbox),
    .key_in     (key_in),
    .block_in   (block_in),
    .done       (done),
    .key_load   (key_load),
    .start      (start),
    .decrypt    (decrypt),
    .sbox_sel   (sbox_sel),
    .key_word   (key_word),
    .block_word (block_word),
    .busy       (busy),
    .cmd_reject (cmd_reject)
  );

  gost_round_engine gost_round_engine_inst (
    .clk        (clk),
    .rst        (rst),
    .key_load   (key_load),
    .start      (start),
    .decrypt    (decrypt),
    .sbox_sel   (sbox_sel),
    .key_word   (key_word),
    .block_word (block_word),
    .out_block  (out_block),
    .done       (done)
  );

  gost_result_reg gost_result_reg_inst (
    .clk            (clk),
    .rst            (rst),
    .done           (done),
    .out_block      (out_block),
    .decrypt        (decrypt),
    .result_valid   (result_valid),
    .result_block   (result_block),
    .result_decrypt (result_decrypt)
  );

endmodule

// ==== rtl/gost_result_reg.sv ====
// GOST result register

module gost_result_reg (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              done,
  input  logic [gost_sbox_pkg::block_w-1:0] out_block,
  input  logic                              decrypt,
  output logic                              result_valid,
  output logic [gost_sbox_pkg::block_w-1:0] result_block,
  output logic                              result_decrypt
);

  //////////////////////////////
  // flags
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid   <= 1'b0;
      result_decrypt <= 1'b0;
    end else begin
      result_valid <= done; // one cycle after the engine finishes
      if (done)
        result_decrypt <= decrypt; // direction still held by the decoder
    end
  end

  //////////////////////////////
  // block capture
  //////////////////////////////

  // held until the next block completes
  always_ff @(posedge clk) begin
    if (done)
      result_block <= out_block;
  end

endmodule

// ==== rtl/gost_round_engine.sv ====
// GOST 28147-89 round engine

module gost_round_engine (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              key_load,
  input  logic                              start,
  input  logic                              decrypt,
  input  gost_sbox_pkg::sbox_set_e          sbox_sel,
  input  logic [gost_sbox_pkg::key_w-1:0]   key_word,
  input  logic [gost_sbox_pkg::block_w-1:0] block_word,
  output logic [gost_sbox_pkg::block_w-1:0] out_block,
  output logic                              done
);

  import gost_sbox_pkg::*;

  logic [half_w-1:0] key_mem [8]; // K0..K7

  logic [4:0] round_cnt;  // 0..31
  logic       active;     // rounds in progress
  logic       last_round;

  logic [half_w-1:0] a; // low half, fed to the round function
  logic [half_w-1:0] b; // high half

  logic [2:0]        enc_idx;
  logic [2:0]        dec_idx;
  logic [2:0]        key_idx;
  logic [half_w-1:0] sum;
  logic [half_w-1:0] subst;
  logic [half_w-1:0] rotated;

  //////////////////////////////
  // key store
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (key_load) begin
      for (int n = 0; n < 8; n++)
        key_mem[n] <= key_word[key_w-1-half_w*n -: half_w]; // K0 in the top word
    end
  end

  //////////////////////////////
  // round counter
  //////////////////////////////

  assign last_round = active && (round_cnt == 5'(num_rounds - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      round_cnt <= 5'd0;
      active    <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= last_round;
      if (start) begin
        round_cnt <= 5'd0;
        active    <= 1'b1;
      end else if (active) begin
        round_cnt <= round_cnt + 5'd1;
        if (last_round)
          active <= 1'b0;
      end
    end
  end

  // encrypt: K0..K7 three times then K7..K0
  assign enc_idx = (&round_cnt[4:3]) ? ~round_cnt[2:0] : round_cnt[2:0];
  // decrypt: K0..K7 once then K7..K0 three times
  assign dec_idx = (|round_cnt[4:3]) ? ~round_cnt[2:0] : round_cnt[2:0];
  assign key_idx = decrypt ? dec_idx : enc_idx;

  //////////////////////////////
  // Feistel datapath
  //////////////////////////////

  assign sum     = a + key_mem[key_idx]; // mod 2^32
  assign subst   = sbox_subst(sum, sbox_sel);
  assign rotated = (subst << 11) | (subst >> (half_w - 11));

  always_ff @(posedge clk) begin
    if (start) begin
      b <= block_word[block_w-1 -: half_w];
      a <= block_word[half_w-1:0];
    end else if (active) begin
      a <= b ^ rotated;
      b <= a; // halves swap every round
    end
  end

  // no swap after the last round, so the output pair is reversed
  assign out_block = {a, b};

endmodule

// ==== rtl/gost_cmd_decode.sv ====
// GOST command decoder

module gost_cmd_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_strobe,
  input  gost_cmd_pkg::cmd_op_e          cmd_op,
  input  gost_sbox_pkg::sbox_set_e       cmd_sbox,
  input  logic [gost_sbox_pkg::key_w-1:0]   key_in,
  input  logic [gost_sbox_pkg::block_w-1:0] block_in,
  input  logic                           done,
  output logic                           key_load,
  output logic                           start,
  output logic                           decrypt,
  output gost_sbox_pkg::sbox_set_e       sbox_sel,
  output logic [gost_sbox_pkg::key_w-1:0]   key_word,
  output logic [gost_sbox_pkg::block_w-1:0] block_word,
  output logic                           busy,
  output logic                           cmd_reject
);

  import gost_cmd_pkg::*;
  import gost_sbox_pkg::*;

  decode_state_e state;

  logic idle_strobe;  // strobe that can be acted on
  logic accept_key;
  logic accept_block;

  assign idle_strobe  = cmd_strobe && (state == st_idle);
  assign accept_key   = idle_strobe && (cmd_op == op_load_key);
  assign accept_block = idle_strobe && (cmd_op == op_encrypt || cmd_op == op_decrypt);

  assign busy = (state == st_running);

  //////////////////////////////
  // control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      key_load   <= 1'b0;
      start      <= 1'b0;
      cmd_reject <= 1'b0;
      decrypt    <= 1'b0;
      sbox_sel   <= set_test;
    end else begin
      key_load   <= 1'b0; // pulses by default
      start      <= 1'b0;
      cmd_reject <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_strobe) begin
            case (cmd_op)
              op_load_key: key_load <= 1'b1; // key copy, stays idle
              op_encrypt, op_decrypt: begin
                start    <= 1'b1;
                decrypt  <= (cmd_op == op_decrypt);
                sbox_sel <= cmd_sbox;
                state    <= st_running;
              end
              op_reserved: cmd_reject <= 1'b1;
            endcase
          end
        end
        st_running: begin
          if (cmd_strobe)
            cmd_reject <= 1'b1; // one block in flight only
          if (done)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // operand words, held for the engine
  always_ff @(posedge clk) begin
    if (accept_key)
      key_word <= key_in;
    if (accept_block)
      block_word <= block_in;
  end

endmodule

// ==== rtl/gost_cmd_pkg.sv ====
// GOST unit command encodings

package gost_cmd_pkg;

  //////////////////////////////
  // host command opcodes
  //////////////////////////////

  typedef enum logic [1:0] {
    op_load_key = 2'b00, // store a new 256-bit key
    op_encrypt  = 2'b01, // one block, encrypt key order
    op_decrypt  = 2'b10, // one block, decrypt key order
    op_reserved = 2'b11  // not a command, always rejected
  } cmd_op_e;

  //////////////////////////////
  // decoder FSM
  //////////////////////////////

  typedef enum logic {
    st_idle    = 1'b0, // ready for a command
    st_running = 1'b1  // a block is in the round engine
  } decode_state_e;

endpackage

// ==== rtl/gost_sbox_pkg.sv ====
// GOST 28147-89 cipher constants and S-boxes

package gost_sbox_pkg;

  localparam int block_w    = 64;  // one cipher block
  localparam int half_w     = 32;  // half block and round key
  localparam int key_w      = 256; // eight round keys
  localparam int num_rounds = 32;

  // which substitution table set a block runs with
  typedef enum logic {
    set_test = 1'b0, // GOST R 34.11-94 test parameters
    set_cpro = 1'b1  // CryptoPro parameters
  } sbox_set_e;

  //////////////////////////////
  // substitution tables, row n serves nibble n
  //////////////////////////////

  localparam logic [3:0] sbox_test [8][16] = '{
    '{4'h4, 4'ha, 4'h9, 4'h2, 4'hd, 4'h8, 4'h0, 4'he,
      4'h6, 4'hb, 4'h1, 4'hc, 4'h7, 4'hf, 4'h5, 4'h3},
    '{4'he, 4'hb, 4'h4, 4'hc, 4'h6, 4'hd, 4'hf, 4'ha,
      4'h2, 4'h3, 4'h8, 4'h1, 4'h0, 4'h7, 4'h5, 4'h9},
    '{4'h5, 4'h8, 4'h1, 4'hd, 4'ha, 4'h3, 4'h4, 4'h2,
      4'he, 4'hf, 4'hc, 4'h7, 4'h6, 4'h0, 4'h9, 4'hb},
    '{4'h7, 4'hd, 4'ha, 4'h1, 4'h0, 4'h8, 4'h9, 4'hf,
      4'he, 4'h4, 4'h6, 4'hc, 4'hb, 4'h2, 4'h5, 4'h3},
    '{4'h6, 4'hc, 4'h7, 4'h1, 4'h5, 4'hf, 4'hd, 4'h8,
      4'h4, 4'ha, 4'h9, 4'he, 4'h0, 4'h3, 4'hb, 4'h2},
    '{4'h4, 4'hb, 4'ha, 4'h0, 4'h7, 4'h2, 4'h1, 4'hd,
      4'h3, 4'h6, 4'h8, 4'h5, 4'h9, 4'hc, 4'hf, 4'he},
    '{4'hd, 4'hb, 4'h4, 4'h1, 4'h3, 4'hf, 4'h5, 4'h9,
      4'h0, 4'ha, 4'he, 4'h7, 4'h6, 4'h8, 4'h2, 4'hc},
    '{4'h1, 4'hf, 4'hd, 4'h0, 4'h5, 4'h7, 4'ha, 4'h4,
      4'h9, 4'h2, 4'h3, 4'he, 4'h6, 4'hb, 4'h8, 4'hc}
  };

  localparam logic [3:0] sbox_cpro [8][16] = '{
    '{4'ha, 4'h4, 4'h5, 4'h6, 4'h8, 4'h1, 4'h3, 4'h7,
      4'hd, 4'hc, 4'he, 4'h0, 4'h9, 4'h2, 4'hb, 4'hf},
    '{4'h5, 4'hf, 4'h4, 4'h0, 4'h2, 4'hd, 4'hb, 4'h9,
      4'h1, 4'h7, 4'h6, 4'h3, 4'hc, 4'he, 4'ha, 4'h8},
    '{4'h7, 4'hf, 4'hc, 4'he, 4'h9, 4'h4, 4'h1, 4'h0,
      4'h3, 4'hb, 4'h5, 4'h2, 4'h6, 4'ha, 4'h8, 4'hd},
    '{4'h4, 4'ha, 4'h7, 4'hc, 4'h0, 4'hf, 4'h2, 4'h8,
      4'he, 4'h1, 4'h6, 4'h5, 4'hd, 4'hb, 4'h9, 4'h3},
    '{4'h7, 4'h6, 4'h4, 4'hb, 4'h9, 4'hc, 4'h2, 4'ha,
      4'h1, 4'h8, 4'h0, 4'he, 4'hf, 4'hd, 4'h3, 4'h5},
    '{4'h7, 4'h6, 4'h2, 4'h4, 4'hd, 4'h9, 4'hf, 4'h0,
      4'ha, 4'h1, 4'h5, 4'hb, 4'h8, 4'he, 4'hc, 4'h3},
    '{4'hd, 4'he, 4'h4, 4'h1, 4'h7, 4'h0, 4'h5, 4'ha,
      4'h3, 4'hc, 4'h8, 4'hf, 4'h6, 4'h2, 4'h9, 4'hb},
    '{4'h1, 4'h3, 4'ha, 4'h9, 4'h5, 4'hb, 4'h4, 4'hf,
      4'h8, 4'h6, 4'h7, 4'he, 4'hd, 4'h0, 4'h2, 4'hc}
  };

  // nibble n of x goes through row n of the chosen set
  function automatic logic [half_w-1:0] sbox_subst(input logic [half_w-1:0] x,
                                                   input sbox_set_e sel);
    logic [half_w-1:0] y;
    y = '0;
    for (int n = 0; n < half_w / 4; n++) begin
      if (sel == set_cpro)
        y[4*n +: 4] = sbox_cpro[n][x[4*n +: 4]];
      else
        y[4*n +: 4] = sbox_test[n][x[4*n +: 4]];
    end
    return y;
  endfunction

endpackage
